// File: Makefile
# Verilator build and run of the RAM tile testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ram_tile
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

# The run may stop through $$fatal, so the log decides the result
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/tb_ram_tile.sv
/* Testbench for the RAM tile top level: reference memory model, random write and
   read traffic, bypass and dual-write cases, and integrity monitor checks */

`timescale 1ns/100ps
`default_nettype none

`include "ram_tile_config.svh"

module tb_ram_tile import ram_tile_pkg::*; ();

  localparam int MAX_CYCLES = 5000;

  logic                                 wr_clk;
  logic                                 wr_rst;
  logic         [`RAM_NUM_WR_PORTS-1:0] wr_valid;
  ram_addr_t    [`RAM_NUM_WR_PORTS-1:0] wr_addr;
  ram_data_t    [`RAM_NUM_WR_PORTS-1:0] wr_data;
  ram_word_en_t [`RAM_NUM_WR_PORTS-1:0] wr_word_en;
  logic         [`RAM_NUM_RD_PORTS-1:0] rd_addr_valid;
  ram_addr_t    [`RAM_NUM_RD_PORTS-1:0] rd_addr;
  logic         [`RAM_NUM_RD_PORTS-1:0] rd_data_valid;
  ram_data_t    [`RAM_NUM_RD_PORTS-1:0] rd_data;
  logic                                 watch_load;
  ram_addr_t                            watch_addr;
  logic                                 integrity_error;
  check_kind_e                          error_kind;

  // Expected contents of the array after every completed edge
  ram_data_t   ref_mem [`RAM_DEPTH];

  ram_tile_top DUT (.*);

  initial begin
    wr_clk = 1'b0;
    forever #50 wr_clk = ~wr_clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input ram_data_t exp, input ram_data_t act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_error("read data differs from the reference model");
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
      stop_with_error("a status bit differs from its expected value");
    end
  endtask

  task automatic check_kind(input string name, input check_kind_e exp,
                            input check_kind_e act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      stop_with_error("the monitor reported an unexpected check kind");
    end
  endtask

  // Word-wise merge: enabled words come from the write, the rest stay as stored
  function automatic ram_data_t merge_words(input ram_data_t stored, input ram_data_t wdata,
                                            input ram_word_en_t wen);
    ram_data_t res;
    res = stored;
    for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
      if (wen[w]) begin
        res[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] = wdata[w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
      end
    end
    return res;
  endfunction

  // Reference array follows the writes seen at each rising edge
  always @(posedge wr_clk) begin
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      if (wr_rst) begin
        ref_mem[a] <= '0;
      end
    end
    if (!wr_rst) begin
      for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
        if (wr_valid[p]) begin
          ref_mem[wr_addr[p]] <= merge_words(ref_mem[wr_addr[p]], wr_data[p], wr_word_en[p]);
        end
      end
    end
  end

  // Mid-cycle compare, where every driven input and combinational output is settled
  always @(negedge wr_clk) begin
    ram_data_t exp_data;
    if (!wr_rst) begin
      for (int r = 0; r < `RAM_NUM_RD_PORTS; r++) begin
        check_valid($sformatf("rd_data_valid[%0d]", r), rd_addr_valid[r], rd_data_valid[r]);
        if (rd_addr_valid[r]) begin
          exp_data = ref_mem[rd_addr[r]];
          // A same-cycle write to the read address is forwarded word by word
          for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
            if (`RAM_ENABLE_BYPASS && wr_valid[p] && (wr_addr[p] == rd_addr[r])) begin
              exp_data = merge_words(exp_data, wr_data[p], wr_word_en[p]);
            end
          end
          check_data($sformatf("rd_data[%0d]", r), exp_data, rd_data[r]);
        end
      end
      check_valid("integrity_error", 1'b0, integrity_error);
      check_kind("error_kind", chk_none, error_kind);
    end
  end

  // Watchdog on the whole run
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge wr_clk);
      cycles++;
    end
    stop_with_error("the simulation ran past its cycle limit without finishing");
  end

  // Inputs change a short time after the rising edge
  task automatic step_cycle();
    @(posedge wr_clk);
    #1;
  endtask

  task automatic clear_inputs();
    wr_valid      = '0;
    rd_addr_valid = '0;
    watch_load    = 1'b0;
  endtask

  task automatic drive_write(input int p, input ram_addr_t addr, input ram_data_t data,
                             input ram_word_en_t wen);
    wr_valid[p]   = 1'b1;
    wr_addr[p]    = addr;
    wr_data[p]    = data;
    wr_word_en[p] = wen;
  endtask

  task automatic drive_read(input int r, input ram_addr_t addr);
    rd_addr_valid[r] = 1'b1;
    rd_addr[r]       = addr;
  endtask

  task automatic wait_monitor_clear(input int limit);
    int count;
    count = 0;
    while (wr_rst || integrity_error || (error_kind != chk_none)) begin
      if (count >= limit) begin
        stop_with_error("the integrity monitor never came back to its clear state");
      end
      step_cycle();
      count++;
    end
  endtask

  task automatic load_watch(input ram_addr_t addr);
    step_cycle();
    clear_inputs();
    watch_load = 1'b1;
    watch_addr = addr;
    step_cycle();
    clear_inputs();
    wait_monitor_clear(8);
  endtask

  // Reads every address, port 1 walking downwards
  task automatic read_all();
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      step_cycle();
      clear_inputs();
      drive_read(0, ram_addr_t'(a));
      drive_read(1, ram_addr_t'(`RAM_DEPTH - 1 - a));
    end
  endtask

  // Half of the picks land on the watched entry
  function automatic ram_addr_t pick_addr(input ram_addr_t hot);
    if ($urandom_range(1, 0) == 0) begin
      return hot;
    end
    return ram_addr_t'($urandom_range(`RAM_DEPTH - 1, 0));
  endfunction

  // Partial writes with a random read alongside, then a same-address read pair
  task automatic mixed_traffic(input ram_addr_t hot, input int n);
    ram_addr_t a;
    for (int i = 0; i < n; i++) begin
      step_cycle();
      clear_inputs();
      a = pick_addr(hot);
      drive_write($urandom_range(1, 0), a, ram_data_t'($urandom()),
                  ram_word_en_t'($urandom()));
      drive_read(0, pick_addr(hot));
      step_cycle();
      clear_inputs();
      a = pick_addr(hot);
      drive_write(0, a, ram_data_t'($urandom()), ram_word_en_t'($urandom()));
      drive_read(0, a);
      drive_read(1, a);
    end
  endtask

  initial begin
    ram_addr_t a0;
    ram_addr_t a1;
    void'($urandom(32'h4355a881));
    wr_rst     = 1'b1;
    wr_valid   = '0;
    wr_addr    = '0;
    wr_data    = '0;
    wr_word_en = '0;
    rd_addr_valid = '0;
    rd_addr    = '0;
    watch_load = 1'b0;
    watch_addr = '0;
    repeat (3) @(posedge wr_clk);
    #1 wr_rst = 1'b0;
    wait_monitor_clear(8);
    // Watch an entry before anything is written, so its reset value is checked
    load_watch(ram_addr_t'(5));
    read_all();
    // Full writes, alternating ports, then a full read-back
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      step_cycle();
      clear_inputs();
      drive_write(a % 2, ram_addr_t'(a), ram_data_t'($urandom()), '1);
    end
    read_all();
    // Partial and bypassed writes, mostly to the watched entry
    mixed_traffic(ram_addr_t'(5), 40);
    read_all();
    // Both write ports in one cycle on distinct addresses
    for (int i = 0; i < 12; i++) begin
      step_cycle();
      clear_inputs();
      a0 = ram_addr_t'($urandom_range(`RAM_DEPTH - 1, 0));
      a1 = a0 + ram_addr_t'($urandom_range(`RAM_DEPTH - 1, 1));
      drive_write(0, a0, ram_data_t'($urandom()), ram_word_en_t'($urandom()));
      drive_write(1, a1, ram_data_t'($urandom()), ram_word_en_t'($urandom()));
      step_cycle();
      clear_inputs();
      drive_read(0, a0);
      drive_read(1, a1);
    end
    // A second watched entry picks up tracking from scratch
    load_watch(ram_addr_t'(10));
    mixed_traffic(ram_addr_t'(10), 40);
    read_all();
    // A reset in the middle of the run must clear every entry that holds data
    step_cycle();
    clear_inputs();
    wr_rst = 1'b1;
    repeat (3) step_cycle();
    wr_rst = 1'b0;
    read_all();
    step_cycle();
    clear_inputs();
    step_cycle();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/ram_tile_pkg.sv
verilog/ram_port_if.sv
verilog/ram_flops_tile.sv
verilog/ram_tile_monitor.sv
verilog/ram_tile_top.sv
dv/tb_ram_tile.sv

// File: verilog/ram_flops_tile.sv
/* Flop-based multi-port storage array with per-word writes, optional reset clear
   and optional same-cycle write-to-read bypass on combinational read ports */

`timescale 1ns/100ps
`default_nettype none

`include "ram_tile_config.svh"

module ram_flops_tile import ram_tile_pkg::*; (
  input logic      wr_clk,
  input logic      wr_rst,
  ram_wr_if.tile   wr,
  ram_rd_if.tile   rd
);

  // Current contents of the array
  ram_data_t mem_q [`RAM_DEPTH];

  // Contents after this cycle's writes are applied
  ram_data_t mem_d [`RAM_DEPTH];

  // Read data per port after the array mux and the bypass merge
  ram_data_t [`RAM_NUM_RD_PORTS-1:0] rd_word;

  // Next-state of the array
  // Each word of each entry takes data from the write port that addresses it
  // with its word enable set, otherwise it keeps its value
  always_comb begin
    mem_d = mem_q;
    for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
      if (wr.valid[p] && (wr.addr[p] < `RAM_DEPTH)) begin
        for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
          if (wr.word_en[p][w]) begin
            mem_d[wr.addr[p]][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
                wr.data[p][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
          end
        end
      end
    end
  end

  // Storage registers
  // With the reset option the whole array clears to zero while wr_rst is high
  if (`RAM_ENABLE_RESET) begin : gen_mem_reset
    always_ff @(posedge wr_clk or posedge wr_rst) begin
      if (wr_rst) begin
        mem_q <= '{default: '0};
      end else begin
        mem_q <= mem_d;
      end
    end
  end else begin : gen_mem_no_reset
    always_ff @(posedge wr_clk) begin
      mem_q <= mem_d;
    end
  end

  // Read muxes, one per read port
  // An out-of-range address reads as zero rather than indexing past the array
  always_comb begin
    for (int r = 0; r < `RAM_NUM_RD_PORTS; r++) begin
      rd_word[r] = '0;
      if (rd.addr[r] < `RAM_DEPTH) begin
        rd_word[r] = mem_q[rd.addr[r]];
      end
      // Bypass merge
      // Enabled words of a same-cycle write to this address replace the stored
      // words, the remaining words still come from the array
      if (`RAM_ENABLE_BYPASS) begin
        for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
          if (wr.valid[p] && (wr.addr[p] == rd.addr[r])) begin
            for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
              if (wr.word_en[p][w]) begin
                rd_word[r][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
                    wr.data[p][w*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
              end
            end
          end
        end
      end
    end
  end

  // Reads never stall, so data is valid in the same cycle as the address
  assign rd.data_valid = rd.addr_valid;
  assign rd.data       = rd_word;

  // Write ports must stay inside the array and never collide on one entry,
  // the tile has no priority between two ports writing the same address
  for (genvar i = 0; i < `RAM_NUM_WR_PORTS; i++) begin : gen_wr_chk
    wr_addr_in_range_a: assert property (
      @(posedge wr_clk) disable iff (wr_rst)
      wr.valid[i] |-> (wr.addr[i] < `RAM_DEPTH));

    for (genvar j = i + 1; j < `RAM_NUM_WR_PORTS; j++) begin : gen_pair
      wr_addr_distinct_a: assert property (
        @(posedge wr_clk) disable iff (wr_rst)
        (wr.valid[i] && wr.valid[j]) |-> (wr.addr[i] != wr.addr[j]));
    end
  end

  // Read addresses from the driver must also stay inside the array
  for (genvar r = 0; r < `RAM_NUM_RD_PORTS; r++) begin : gen_rd_chk
    rd_addr_in_range_a: assert property (
      @(posedge wr_clk) disable iff (wr_rst)
      rd.addr_valid[r] |-> (rd.addr[r] < `RAM_DEPTH));
  end

endmodule

`default_nettype wire

// File: verilog/ram_port_if.sv
/* Write-port and read-port bundles of the RAM tile, one element per port,
   with driver, tile and monitor views */

`timescale 1ns/100ps
`default_nettype none

`include "ram_tile_config.svh"

interface ram_wr_if import ram_tile_pkg::*; ();

  logic         [`RAM_NUM_WR_PORTS-1:0] valid;
  ram_addr_t    [`RAM_NUM_WR_PORTS-1:0] addr;
  ram_data_t    [`RAM_NUM_WR_PORTS-1:0] data;
  ram_word_en_t [`RAM_NUM_WR_PORTS-1:0] word_en;

  modport driver (output valid, addr, data, word_en);
  modport tile (input valid, addr, data, word_en);
  modport monitor (input valid, addr, data, word_en);

endinterface

interface ram_rd_if import ram_tile_pkg::*; ();

  logic      [`RAM_NUM_RD_PORTS-1:0] addr_valid;
  ram_addr_t [`RAM_NUM_RD_PORTS-1:0] addr;
  logic      [`RAM_NUM_RD_PORTS-1:0] data_valid;
  ram_data_t [`RAM_NUM_RD_PORTS-1:0] data;

  // The driver owns the address half and the tile returns the data half
  modport driver (output addr_valid, addr, input data_valid, data);
  modport tile (input addr_valid, addr, output data_valid, data);
  modport monitor (input addr_valid, addr, data_valid, data);

endinterface

`default_nettype wire

// File: verilog/ram_tile_config.svh
/* Configuration macros for the flop RAM tile: geometry, word size, port counts
   and the bypass and reset options */

`ifndef RAM_TILE_CONFIG_SVH
`define RAM_TILE_CONFIG_SVH

// Number of entries in the storage array
`define RAM_DEPTH 16

// Bits per entry
`define RAM_WIDTH 32

// Smallest unit a partial write can update, RAM_WIDTH must be a multiple of it
`define RAM_WORD_WIDTH 8

// Words per entry, one word-enable bit each
`define RAM_NUM_WORDS (`RAM_WIDTH / `RAM_WORD_WIDTH)

// Address width, never below one bit even for a single-entry array
`define RAM_ADDR_WIDTH ((`RAM_DEPTH > 1) ? $clog2(`RAM_DEPTH) : 1)

// Port counts
`define RAM_NUM_WR_PORTS 2
`define RAM_NUM_RD_PORTS 2

// Forward same-cycle write data to a read of the same address
`define RAM_ENABLE_BYPASS 1'b1

// Clear every entry to zero while reset is high
`define RAM_ENABLE_RESET 1'b1

`endif

// File: verilog/ram_tile_monitor.sv
/* Integrity monitor for the RAM tile: tracks a shadow copy of one watched entry
   and flags any read of that entry that disagrees with it */

`timescale 1ns/100ps
`default_nettype none

`include "ram_tile_config.svh"

module ram_tile_monitor import ram_tile_pkg::*; (
  input  logic        wr_clk,
  input  logic        wr_rst,
  ram_wr_if.monitor   wr,
  ram_rd_if.monitor   rd,
  input  logic        watch_load,
  input  ram_addr_t   watch_addr,
  output logic        integrity_error,
  output check_kind_e error_kind
);

  // Watched address and the shadow copy of its entry
  ram_addr_t    watch_addr_q;
  ram_data_t    shadow_q;
  ram_data_t    shadow_nxt;
  // Words of the shadow that hold known data
  ram_word_en_t word_written_q;
  // Set once the watched entry may differ from its reset value
  logic         wr_seen_q;
  // Set once any entry has been written since reset
  logic         any_wr_q;
  // The write hitting the watched address this cycle, at most one port
  logic         sel_valid;
  ram_data_t    sel_data;
  ram_word_en_t sel_word_en;
  // Expected value and check kind per word of the watched entry
  check_kind_e  word_kind [`RAM_NUM_WORDS];
  ram_data_t    expect_data;
  logic [`RAM_NUM_RD_PORTS-1:0] rd_hit;
  logic         mismatch;
  check_kind_e  mismatch_kind;

  // Pick the write port aimed at the watched address
  // Distinct write addresses make this selection one-hot
  always_comb begin
    sel_valid   = 1'b0;
    sel_data    = '0;
    sel_word_en = '0;
    for (int p = 0; p < `RAM_NUM_WR_PORTS; p++) begin
      if (wr.valid[p] && (wr.addr[p] == watch_addr_q)) begin
        sel_valid   = 1'b1;
        sel_data    = wr.data[p];
        sel_word_en = wr.word_en[p];
      end
    end
  end

  // Shadow value after this cycle's write, merged word by word
  for (genvar n = 0; n < `RAM_NUM_WORDS; n++) begin : gen_merge
    assign shadow_nxt[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] = sel_word_en[n] ?
        sel_data[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] :
        shadow_q[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
  end

  // Shadow data only counts where word_written_q says so
  always_ff @(posedge wr_clk) begin
    if (sel_valid) begin
      shadow_q <= shadow_nxt;
    end
  end

  // Tracking state
  // A new watched address starts with no known words, and it keeps its reset
  // value only if nothing at all has been written so far
  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      watch_addr_q   <= '0;
      word_written_q <= '0;
      wr_seen_q      <= 1'b0;
      any_wr_q       <= 1'b0;
    end else begin
      any_wr_q <= any_wr_q | (|wr.valid);
      if (watch_load) begin
        watch_addr_q   <= watch_addr;
        word_written_q <= '0;
        wr_seen_q      <= any_wr_q | (|wr.valid);
      end else if (sel_valid) begin
        word_written_q <= word_written_q | sel_word_en;
        wr_seen_q      <= 1'b1;
      end
    end
  end

  // Classify each word of the watched entry
  // Bypassed words win over stored ones, and the reset value only applies
  // to an entry that was never written
  always_comb begin
    for (int n = 0; n < `RAM_NUM_WORDS; n++) begin
      word_kind[n] = chk_none;
      expect_data[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] = '0;
      if (`RAM_ENABLE_BYPASS && sel_valid && sel_word_en[n]) begin
        word_kind[n] = chk_bypassed;
        expect_data[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
            shadow_nxt[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
      end else if (word_written_q[n]) begin
        word_kind[n] = chk_stored;
        expect_data[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] =
            shadow_q[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH];
      end else if (`RAM_ENABLE_RESET && !wr_seen_q) begin
        word_kind[n] = chk_reset_value;
      end
    end
  end

  // Compare every read port that reads the watched entry
  // The first failing port and word in scan order names the kind
  always_comb begin
    mismatch      = 1'b0;
    mismatch_kind = chk_none;
    for (int r = 0; r < `RAM_NUM_RD_PORTS; r++) begin
      rd_hit[r] = rd.addr_valid[r] && (rd.addr[r] == watch_addr_q);
      for (int n = 0; n < `RAM_NUM_WORDS; n++) begin
        if (rd_hit[r] && (word_kind[n] != chk_none) && !mismatch &&
            (rd.data[r][n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] !=
             expect_data[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH])) begin
          mismatch      = 1'b1;
          mismatch_kind = word_kind[n];
        end
      end
    end
  end

  // Sticky error flag, cleared only by reset or a new watched address
  always_ff @(posedge wr_clk or posedge wr_rst) begin
    if (wr_rst) begin
      integrity_error <= 1'b0;
      error_kind      <= chk_none;
    end else if (watch_load) begin
      integrity_error <= 1'b0;
      error_kind      <= chk_none;
    end else if (mismatch && !integrity_error) begin
      integrity_error <= 1'b1;
      error_kind      <= mismatch_kind;
    end
  end

  for (genvar r = 0; r < `RAM_NUM_RD_PORTS; r++) begin : gen_rd_chk
    // The tile answers every read address in the same cycle
    rd_data_valid_a: assert property (
      @(posedge wr_clk) disable iff (wr_rst)
      rd.addr_valid[r] |-> rd.data_valid[r]);

    // Tile read data agrees with the shadow for every known word
    for (genvar n = 0; n < `RAM_NUM_WORDS; n++) begin : gen_word
      shadow_match_a: assert property (
        @(posedge wr_clk) disable iff (wr_rst)
        (rd_hit[r] && (word_kind[n] != chk_none)) |->
        (rd.data[r][n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH] ==
         expect_data[n*`RAM_WORD_WIDTH +: `RAM_WORD_WIDTH]));
    end
  end

endmodule

`default_nettype wire

// File: verilog/ram_tile_pkg.sv
/* Shared types of the RAM tile: address, entry and word-enable types and
   the kind of check the monitor applied to a read */

`default_nettype none

`include "ram_tile_config.svh"

package ram_tile_pkg;

  // One entry address
  typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

  // One full entry
  typedef logic [`RAM_WIDTH-1:0] ram_data_t;

  // One bit per word of an entry, set bits are written
  typedef logic [`RAM_NUM_WORDS-1:0] ram_word_en_t;

  // What a read of the watched entry was compared against
  // Also latched as the kind of the first failing check
  typedef enum logic [1:0] {
    chk_none,
    chk_reset_value,
    chk_stored,
    chk_bypassed
  } check_kind_e;

endpackage

`default_nettype wire

// File: verilog/ram_tile_top.sv
/* Top level of the RAM tile: plain port bundles onto the write and read
   interfaces, the storage tile and its integrity monitor */

`timescale 1ns/100ps
`default_nettype none

`include "ram_tile_config.svh"

module ram_tile_top import ram_tile_pkg::*; (
  input  logic                                 wr_clk,
  input  logic                                 wr_rst,
  // Write ports, one element per port
  input  logic         [`RAM_NUM_WR_PORTS-1:0] wr_valid,
  input  ram_addr_t    [`RAM_NUM_WR_PORTS-1:0] wr_addr,
  input  ram_data_t    [`RAM_NUM_WR_PORTS-1:0] wr_data,
  input  ram_word_en_t [`RAM_NUM_WR_PORTS-1:0] wr_word_en,
  // Read ports, one element per port
  input  logic         [`RAM_NUM_RD_PORTS-1:0] rd_addr_valid,
  input  ram_addr_t    [`RAM_NUM_RD_PORTS-1:0] rd_addr,
  output logic         [`RAM_NUM_RD_PORTS-1:0] rd_data_valid,
  output ram_data_t    [`RAM_NUM_RD_PORTS-1:0] rd_data,
  // Monitor control and status
  input  logic                                 watch_load,
  input  ram_addr_t                            watch_addr,
  output logic                                 integrity_error,
  output check_kind_e                          error_kind
);

  ram_wr_if wr_bus ();
  ram_rd_if rd_bus ();

  // Write bundle comes straight from the plain ports
  assign wr_bus.valid   = wr_valid;
  assign wr_bus.addr    = wr_addr;
  assign wr_bus.data    = wr_data;
  assign wr_bus.word_en = wr_word_en;

  // Read addresses go in, tile data comes back out with no added latency
  assign rd_bus.addr_valid = rd_addr_valid;
  assign rd_bus.addr       = rd_addr;
  assign rd_data_valid     = rd_bus.data_valid;
  assign rd_data           = rd_bus.data;

  ram_flops_tile u_tile (
    .wr_clk (wr_clk),
    .wr_rst (wr_rst),
    .wr     (wr_bus.tile),
    .rd     (rd_bus.tile)
  );

  // Observes both bundles without driving any of their signals
  ram_tile_monitor u_monitor (
    .wr_clk          (wr_clk),
    .wr_rst          (wr_rst),
    .wr              (wr_bus.monitor),
    .rd              (rd_bus.monitor),
    .watch_load      (watch_load),
    .watch_addr      (watch_addr),
    .integrity_error (integrity_error),
    .error_kind      (error_kind)
  );

endmodule

`default_nettype wire
